//--- logic/adc_pnmon_config.svh
/*
  Build-time constants for the ADC PN-sequence monitor.
  Included by every file that sizes a port or compares against a run length.
*/

`ifndef ADC_PNMON_CONFIG_SVH
`define ADC_PNMON_CONFIG_SVH

// Width of one converter sample
`define ADC_PN_SAMPLE_W 16

// Consecutive matching words before lock is declared
`define ADC_PN_LOCK_RUN 16

// Consecutive mismatching words before sync is dropped
`define ADC_PN_LOSE_RUN 16

// Saturating error tally width
`define ADC_PN_ERR_W 16

// Run counter width, must hold the larger run length
`define ADC_PN_RUN_W 5

`endif

//--- logic/adc_pnmon_pkg.sv
/*
  Shared types for the PN monitor.
  The paired ADC word is seen as two samples by the packer and as a
  single PN word by the predictor, hence the packed union.
  Blocks refer to these types by scoped name.
*/

`include "adc_pnmon_config.svh"

package adc_pnmon_pkg;

  // ********************
  // Paired word
  // ********************

  // Two views of the same 32 bits
  typedef union packed {
    // Older sample sits in the upper half
    struct packed {
      logic [`ADC_PN_SAMPLE_W-1:0] first;
      logic [`ADC_PN_SAMPLE_W-1:0] second;
    } samples;
    // Whole word as the PN generator sees it, newest bit at bit 0
    logic [2*`ADC_PN_SAMPLE_W-1:0] pn;
  } adc_pn_word_t;

  // ********************
  // Sync state
  // ********************

  // Encoded so the state bit equals the out-of-sync level
  typedef enum logic {
    pn_lock = 1'b0,
    pn_oos  = 1'b1
  } adc_pn_state_t;

endpackage

//--- logic/adc_pn_word_pack.sv
/*
  Sample pairing for the PN monitor.
  Two consecutive ADC samples form one 32-bit word, older one on top.
  word_valid marks the cycle in which word holds a complete pair,
  every second cycle, starting with the pair received after reset.
*/

`timescale 1ns/1ps

`include "adc_pnmon_config.svh"

module adc_pn_word_pack (
  input  logic                        adc_clk,
  input  logic                        arst_n,
  input  logic [`ADC_PN_SAMPLE_W-1:0] adc_data,
  output adc_pnmon_pkg::adc_pn_word_t word,
  output logic                        word_valid
);

  // Pair phase, high while the second sample of a pair is on adc_data
  logic phase;

  // ********************
  // Phase and strobe
  // ********************

  // Strobe lags the phase by one cycle so it lines up with the shifted word
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      phase      <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      phase      <= ~phase;
      word_valid <= phase;
    end
  end

  // ********************
  // Sample shift
  // ********************

  // Older sample moves to the upper half, new sample enters below
  always_ff @(posedge adc_clk) begin
    word.samples.first  <= word.samples.second;
    word.samples.second <= adc_data;
  end

endmodule

//--- logic/adc_pn_predict.sv
/*
  PN word predictor and comparator.
  Each received word is compared with the word predicted from the one
  before it. Out of sync the predictor reseeds from the received word,
  in sync it free-runs from its own prediction.
  pnseq_sel of zero picks PN9, anything else picks PN23.
*/

`timescale 1ns/1ps

module adc_pn_predict (
  input  logic                        adc_clk,
  input  logic                        arst_n,
  input  adc_pnmon_pkg::adc_pn_word_t word,
  input  logic                        word_valid,
  input  logic [3:0]                  pnseq_sel,
  input  logic                        oos,
  output logic                        match,
  output logic                        match_valid
);

  // Bits produced per generator step, one full word
  localparam int unsigned word_w = $bits(adc_pnmon_pkg::adc_pn_word_t);

  // Held prediction for the next received word
  logic [word_w-1:0] pred;
  // Word the next prediction is grown from
  logic [word_w-1:0] seed;
  logic [word_w-1:0] next_pred;

  // ********************
  // PN step functions
  // ********************

  // x^9 + x^5 + 1, one word of new bits, newest bit lands at bit 0
  function automatic logic [word_w-1:0] pn9_step(input logic [word_w-1:0] din);
    logic [word_w-1:0] sr;
    sr = din;
    for (int i = 0; i < word_w; i++) begin
      // Taps sit 9 and 5 bits back from the bit being made
      sr = {sr[word_w-2:0], sr[8] ^ sr[4]};
    end
    return sr;
  endfunction

  // x^23 + x^18 + 1, same bit ordering as PN9
  function automatic logic [word_w-1:0] pn23_step(input logic [word_w-1:0] din);
    logic [word_w-1:0] sr;
    sr = din;
    for (int i = 0; i < word_w; i++) begin
      // Taps 23 and 18 bits back
      sr = {sr[word_w-2:0], sr[22] ^ sr[17]};
    end
    return sr;
  endfunction

  // ********************
  // Seed and next word
  // ********************

  // Out of sync, trust the line and predict from what just arrived
  assign seed = oos ? word.pn : pred;

  // Pattern select, only zero means PN9
  assign next_pred = (pnseq_sel == 4'd0) ? pn9_step(seed) : pn23_step(seed);

  // ********************
  // Compare and advance
  // ********************

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      pred        <= '0;
      match       <= 1'b0;
      match_valid <= 1'b0;
    end else begin
      // Result is valid the cycle after the word
      match_valid <= word_valid;
      if (word_valid) begin
        // Compare against the prediction made from the previous word
        match <= (word.pn == pred);
        pred  <= next_pred;
      end
    end
  end

endmodule

//--- logic/adc_pn_sync_fsm.sv
/*
  Sync state machine for the PN monitor.
  Locks after a run of matching words, drops sync after a run of
  mismatching words. Drives the run counter commands and a one-cycle
  error pulse for every mismatching word seen while locked.
*/

`timescale 1ns/1ps

module adc_pn_sync_fsm (
  input  logic adc_clk,
  input  logic arst_n,
  input  logic match,
  input  logic match_valid,
  input  logic lock_run_done,
  input  logic lose_run_done,
  output logic oos,
  output logic pn_err,
  output logic run_clr,
  output logic run_inc,
  output logic err_inc
);

  adc_pnmon_pkg::adc_pn_state_t state;
  adc_pnmon_pkg::adc_pn_state_t state_nxt;
  // Mismatch while locked gets registered into the error pulse
  logic err_nxt;
  logic err_q;

  // ********************
  // Next state
  // ********************

  always_comb begin
    state_nxt = state;
    run_clr   = 1'b0;
    run_inc   = 1'b0;
    err_nxt   = 1'b0;
    // Nothing moves between compare results
    if (match_valid) begin
      case (state)
        adc_pnmon_pkg::pn_oos: begin
          if (match && lock_run_done) begin
            // Run is long enough so declare lock and start fresh
            state_nxt = adc_pnmon_pkg::pn_lock;
            run_clr   = 1'b1;
          end else if (match) begin
            run_inc = 1'b1;
          end else begin
            // Any miss restarts the lock run
            run_clr = 1'b1;
          end
        end
        adc_pnmon_pkg::pn_lock: begin
          if (!match) begin
            // Every miss while locked counts as a bit error
            err_nxt = 1'b1;
            if (lose_run_done) begin
              state_nxt = adc_pnmon_pkg::pn_oos;
              run_clr   = 1'b1;
            end else begin
              run_inc = 1'b1;
            end
          end else begin
            // A good word breaks the loss run
            run_clr = 1'b1;
          end
        end
      endcase
    end
  end

  // ********************
  // State and pulses
  // ********************

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= adc_pnmon_pkg::pn_oos;
      err_q <= 1'b0;
    end else begin
      state <= state_nxt;
      err_q <= err_nxt;
    end
  end

  // Out-of-sync level straight from the state flop
  assign oos = (state == adc_pnmon_pkg::pn_oos);

  // Error strobe and tally increment come from the same flop
  assign pn_err  = err_q;
  assign err_inc = err_q;

endmodule

//--- logic/adc_pn_run_counter.sv
/*
  Run counter and error tally for the PN monitor.
  The run count is cleared and advanced by the sync FSM, and its
  threshold decodes feed back to it. The error tally counts locked
  mismatches, sticks at all ones and is cleared by err_clr.
*/

`timescale 1ns/1ps

`include "adc_pnmon_config.svh"

module adc_pn_run_counter (
  input  logic                     adc_clk,
  input  logic                     arst_n,
  input  logic                     run_clr,
  input  logic                     run_inc,
  input  logic                     err_inc,
  input  logic                     err_clr,
  output logic                     lock_run_done,
  output logic                     lose_run_done,
  output logic [`ADC_PN_ERR_W-1:0] err_count
);

  localparam int unsigned run_w = `ADC_PN_RUN_W;
  // Count seen on the last word of each run
  localparam logic [run_w-1:0] lock_last = run_w'(`ADC_PN_LOCK_RUN - 1);
  localparam logic [run_w-1:0] lose_last = run_w'(`ADC_PN_LOSE_RUN - 1);

  logic [run_w-1:0] run_cnt;

  // Clear has priority, the FSM never raises both
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      run_cnt <= '0;
    end else if (run_clr) begin
      run_cnt <= '0;
    end else if (run_inc) begin
      run_cnt <= run_cnt + 1'b1;
    end
  end

  // Threshold decodes, checked together with the current word
  assign lock_run_done = (run_cnt == lock_last);
  assign lose_run_done = (run_cnt == lose_last);

  // Error tally, a clear in the same cycle wins
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      err_count <= '0;
    end else if (err_clr) begin
      err_count <= '0;
    end else if (err_inc && (err_count != '1)) begin
      err_count <= err_count + 1'b1;
    end
  end

endmodule

//--- logic/adc_pnmon_top.sv
/*
  PN-sequence monitor for a 16-bit ADC data path.
  Pairs samples into words, predicts PN9 or PN23, tracks sync and
  counts word errors. Used during interface calibration with the
  converter in test-pattern mode.
*/

`timescale 1ns/1ps

`include "adc_pnmon_config.svh"

module adc_pnmon_top (
  input  logic                        adc_clk,
  input  logic                        arst_n,
  input  logic [`ADC_PN_SAMPLE_W-1:0] adc_data,
  input  logic [3:0]                  pnseq_sel,
  input  logic                        err_clr,
  output logic                        pn_oos,
  output logic                        pn_err,
  output logic [`ADC_PN_ERR_W-1:0]    err_count
);

  // Paired word and its strobe
  adc_pnmon_pkg::adc_pn_word_t word;
  logic word_valid;
  // Compare result
  logic match;
  logic match_valid;
  // FSM to counter commands and back
  logic run_clr;
  logic run_inc;
  logic err_inc;
  logic lock_run_done;
  logic lose_run_done;

  adc_pn_word_pack i_word_pack (
    .adc_clk    (adc_clk),
    .arst_n     (arst_n),
    .adc_data   (adc_data),
    .word       (word),
    .word_valid (word_valid)
  );

  adc_pn_predict i_predict (
    .adc_clk     (adc_clk),
    .arst_n      (arst_n),
    .word        (word),
    .word_valid  (word_valid),
    .pnseq_sel   (pnseq_sel),
    .oos         (pn_oos),
    .match       (match),
    .match_valid (match_valid)
  );

  adc_pn_sync_fsm i_sync_fsm (
    .adc_clk       (adc_clk),
    .arst_n        (arst_n),
    .match         (match),
    .match_valid   (match_valid),
    .lock_run_done (lock_run_done),
    .lose_run_done (lose_run_done),
    .oos           (pn_oos),
    .pn_err        (pn_err),
    .run_clr       (run_clr),
    .run_inc       (run_inc),
    .err_inc       (err_inc)
  );

  adc_pn_run_counter i_run_counter (
    .adc_clk       (adc_clk),
    .arst_n        (arst_n),
    .run_clr       (run_clr),
    .run_inc       (run_inc),
    .err_inc       (err_inc),
    .err_clr       (err_clr),
    .lock_run_done (lock_run_done),
    .lose_run_done (lose_run_done),
    .err_count     (err_count)
  );

endmodule

//--- testbench/adc_pnmon_assert.sv
/*
  Concurrent checks on the PN monitor top level.
  Bound into the top level, reads its ports and the compare strobe.
*/

`timescale 1ns/1ps

`include "adc_pnmon_config.svh"

module adc_pnmon_assert (
  input logic                     adc_clk,
  input logic                     arst_n,
  input logic                     err_clr,
  input logic                     pn_oos,
  input logic                     pn_err,
  input logic                     match_valid,
  input logic [`ADC_PN_ERR_W-1:0] err_count
);

  // Sync state, same encoding as the FSM flop
  adc_pnmon_pkg::adc_pn_state_t sync_state;
  assign sync_state = adc_pnmon_pkg::adc_pn_state_t'(pn_oos);

  // Error pulse only after a compare made while locked
  err_only_locked: assert property (@(posedge adc_clk) disable iff (!arst_n)
    pn_err |-> ($past(sync_state) == adc_pnmon_pkg::pn_lock))
    else $error("pn_err raised for a word seen out of sync");

  // Tally only moves down through a clear
  tally_monotonic: assert property (@(posedge adc_clk) disable iff (!arst_n)
    !$past(err_clr) |-> (err_count >= $past(err_count)))
    else $error("err_count decreased without err_clr");

  // Lock is declared only on a compare result
  lock_on_compare: assert property (@(posedge adc_clk) disable iff (!arst_n)
    $fell(pn_oos) |-> $past(match_valid))
    else $error("pn_oos fell without a compare result");

endmodule

bind adc_pnmon_top adc_pnmon_assert i_pnmon_assert (
  .adc_clk     (adc_clk),
  .arst_n      (arst_n),
  .err_clr     (err_clr),
  .pn_oos      (pn_oos),
  .pn_err      (pn_err),
  .match_valid (match_valid),
  .err_count   (err_count)
);

//--- testbench/adc_pnmon_tb.sv
/*
  Directed testbench for the ADC PN-sequence monitor.
  Streams PN9, PN23 and random words through the top level, two samples
  per word, and checks lock, error pulses, loss of sync and the tally.
  Expected values come from a bit-serial PN model kept here.
*/

`timescale 1ns/1ps

`include "adc_pnmon_config.svh"

module adc_pnmon_tb;

  localparam int word_w     = 2 * `ADC_PN_SAMPLE_W;
  localparam int lock_bound = `ADC_PN_LOCK_RUN + 2;
  localparam int lose_bound = `ADC_PN_LOSE_RUN + 2;

  logic                        adc_clk;
  logic                        arst_n;
  logic [`ADC_PN_SAMPLE_W-1:0] adc_data;
  logic [3:0]                  pnseq_sel;
  logic                        err_clr;
  logic                        pn_oos;
  logic                        pn_err;
  logic [`ADC_PN_ERR_W-1:0]    err_count;

  // Run bookkeeping
  int unsigned n_tests;
  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned test_base;
  // Cycles with pn_err high since last cleared
  int unsigned err_seen;
  // Next clean word of the reference stream
  logic [word_w-1:0] next_word;
  bit                use_pn23;

  adc_pnmon_top i_adc_pnmon_top (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .adc_data  (adc_data),
    .pnseq_sel (pnseq_sel),
    .err_clr   (err_clr),
    .pn_oos    (pn_oos),
    .pn_err    (pn_err),
    .err_count (err_count)
  );

  // 100 ns period
  always #50 adc_clk = ~adc_clk;

  // ********************
  // Reference model
  // ********************

  // Bit history oldest first
  // Each new bit is the XOR of two older ones
  function automatic logic [word_w-1:0] pn_model_next(input logic [word_w-1:0] cur,
                                                      input bit pn23);
    logic              hist [0:2*word_w-1];
    logic [word_w-1:0] nxt;
    int                tap_a;
    int                tap_b;
    // x^9+x^5+1 or x^23+x^18+1
    tap_a = pn23 ? 23 : 9;
    tap_b = pn23 ? 18 : 5;
    for (int t = 0; t < word_w; t++) begin
      hist[t] = cur[word_w-1-t];
    end
    for (int t = word_w; t < 2*word_w; t++) begin
      hist[t] = hist[t-tap_a] ^ hist[t-tap_b];
    end
    // First new bit lands at the top of the word
    for (int t = 0; t < word_w; t++) begin
      nxt[word_w-1-t] = hist[word_w+t];
    end
    return nxt;
  endfunction

  // ********************
  // Check and report
  // ********************

  task automatic check_val(input string what, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    n_checks++;
    if (exp_val !== act_val) begin
      n_errors++;
      $display("ERR @ %0t: %s, expected %0h, got %0h", $time, what, exp_val, act_val);
    end
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("Timeout at %0t: %s did not happen in time", $time, what);
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    $display("Test %s done with %0d errors", name, n_errors - test_base);
    test_base = n_errors;
  endtask

  // ********************
  // Stimulus
  // ********************

  // One word as two samples with the upper half first
  // err_clr rides with the upper half
  task automatic drive_word(input logic [word_w-1:0] w, input bit clr);
    adc_data = w[word_w-1 -: `ADC_PN_SAMPLE_W];
    err_clr  = clr;
    @(posedge adc_clk);
    #1;
    if (pn_err) err_seen++;
    if (clr) check_val("err_count one cycle after err_clr", 32'd0, 32'(err_count));
    adc_data = w[`ADC_PN_SAMPLE_W-1:0];
    err_clr  = 1'b0;
    @(posedge adc_clk);
    #1;
    if (pn_err) err_seen++;
  endtask

  task automatic send_next();
    drive_word(next_word, 1'b0);
    next_word = pn_model_next(next_word, use_pn23);
  endtask

  // Keeps the stream going until pn_oos reaches the level or bound words have gone
  task automatic wait_oos(input logic level, input int bound, input bit rand_data,
                          input string what);
    int n;
    n = 0;
    while (pn_oos !== level && n < bound) begin
      if (rand_data) drive_word($urandom(), 1'b0);
      else send_next();
      n++;
    end
    if (pn_oos !== level) report_timeout(what);
  endtask

  // No word may be flagged on a clean locked stream
  task automatic check_clean_run(input string what);
    int unsigned base_cnt;
    err_seen = 0;
    base_cnt = 32'(err_count);
    repeat (64) send_next();
    check_val({"pn_err cycles on clean ", what}, 32'd0, err_seen);
    check_val({"err_count on clean ", what}, base_cnt, 32'(err_count));
    check_val({"pn_oos after clean ", what}, 32'd0, 32'(pn_oos));
  endtask

  // ********************
  // Tests
  // ********************

  task automatic test_reset();
    repeat (16) @(posedge adc_clk);
    #1;
    // First sample of the stream goes out together with the release
    arst_n = 1'b1;
    check_val("pn_oos after reset", 32'd1, 32'(pn_oos));
    check_val("pn_err after reset", 32'd0, 32'(pn_err));
    check_val("err_count after reset", 32'd0, 32'(err_count));
    finish_test("reset state");
  endtask

  task automatic test_pn9_lock();
    use_pn23  = 1'b0;
    pnseq_sel = 4'd0;
    // Bit 0 set keeps the generator state nonzero
    next_word = $urandom() | 32'h1;
    wait_oos(1'b0, lock_bound, 1'b0, "lock on PN9");
    check_clean_run("PN9");
    finish_test("PN9 lock");
  endtask

  task automatic test_single_error();
    logic [word_w-1:0] sent;
    int unsigned       flip;
    int unsigned       exp_err;
    int unsigned       base_cnt;
    err_seen = 0;
    exp_err  = 0;
    base_cnt = 32'(err_count);
    flip     = $urandom() % word_w;
    for (int i = 0; i < 9; i++) begin
      sent = next_word;
      if (i == 4) sent = next_word ^ (32'h1 << flip);
      // Locked DUT predicts the clean stream, so every differing word counts
      if (sent != next_word) exp_err++;
      drive_word(sent, 1'b0);
      next_word = pn_model_next(next_word, use_pn23);
      check_val("pn_oos around a corrupted word", 32'd0, 32'(pn_oos));
    end
    check_val("pn_err pulses for one corrupted word", exp_err, err_seen);
    check_val("err_count growth for one corrupted word", base_cnt + exp_err,
              32'(err_count));
    finish_test("single-word error");
  endtask

  task automatic test_pn23_lock();
    use_pn23  = 1'b1;
    pnseq_sel = 4'd5;
    next_word = $urandom() | 32'h1;
    // Held PN9 prediction misses until sync is dropped
    wait_oos(1'b1, lose_bound, 1'b0, "loss of PN9 lock after switch to PN23");
    wait_oos(1'b0, lock_bound, 1'b0, "lock on PN23");
    check_clean_run("PN23");
    finish_test("PN23 lock");
  endtask

  task automatic test_loss();
    int unsigned base_cnt;
    base_cnt = 32'(err_count);
    wait_oos(1'b1, lose_bound, 1'b1, "loss of sync on random data");
    // Tally takes the last locked miss one cycle after its pulse
    drive_word($urandom(), 1'b0);
    // Each locked miss up to the loss counts once
    check_val("err_count after loss of sync", base_cnt + `ADC_PN_LOSE_RUN,
              32'(err_count));
    finish_test("loss of sync");
  endtask

  task automatic test_tally_clear();
    check_val("err_count nonzero before clear", 32'd1, 32'(err_count != '0));
    drive_word($urandom(), 1'b1);
    // Nothing counts again while out of sync on random data
    drive_word($urandom(), 1'b0);
    check_val("err_count stays cleared", 32'd0, 32'(err_count));
    finish_test("tally clear");
  endtask

  initial begin
    void'($urandom(32'hd213_0059));
    adc_clk   = 1'b0;
    arst_n    = 1'b0;
    adc_data  = '0;
    pnseq_sel = 4'd0;
    err_clr   = 1'b0;
    n_tests   = 0;
    n_checks  = 0;
    n_errors  = 0;
    test_base = 0;
    err_seen  = 0;
    next_word = '0;
    use_pn23  = 1'b0;

    test_reset();
    test_pn9_lock();
    test_single_error();
    test_pn23_lock();
    test_loss();
    test_tally_clear();

    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- adc_pnmon.f
+incdir+logic
logic/adc_pnmon_pkg.sv
logic/adc_pn_word_pack.sv
logic/adc_pn_predict.sv
logic/adc_pn_sync_fsm.sv
logic/adc_pn_run_counter.sv
logic/adc_pnmon_top.sv
testbench/adc_pnmon_assert.sv
testbench/adc_pnmon_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the PN monitor testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module adc_pnmon_tb \
  -f adc_pnmon.f \
  -o adc_pnmon_sim

# A failed assertion may end the run early, the log decides
./obj_dir/adc_pnmon_sim > sim.log 2>&1 || true
cat sim.log

if grep -qxF '** PASS **' sim.log; then
  exit 0
fi
exit 1
